// File: csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // CSR instruction opcodes as issued by decode
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [1:0] {
        MODE_USER       = 2'b00,
        MODE_SUPERVISOR = 2'b01,
        MODE_MACHINE    = 2'b11
    } priv_mode_e;

    // Kinds of privilege state change
    typedef enum logic [2:0] {
        TRAP_NONE       = 3'd0,
        TRAP_MACHINE    = 3'd1,
        TRAP_SUPERVISOR = 3'd2,
        TRAP_MRET       = 3'd3,
        TRAP_ECALL      = 3'd4
    } trap_kind_e;

    // Counters
    localparam csr_addr_t ADDR_CYCLE      = 12'hc00;
    localparam csr_addr_t ADDR_TIME       = 12'hc01;
    localparam csr_addr_t ADDR_CYCLEH     = 12'hc80;
    localparam csr_addr_t ADDR_TIMEH      = 12'hc81;

    // Machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS    = 12'h300;
    localparam csr_addr_t ADDR_MIDELEG    = 12'h303;
    localparam csr_addr_t ADDR_MIE        = 12'h304;
    localparam csr_addr_t ADDR_MTVEC      = 12'h305;
    localparam csr_addr_t ADDR_MCOUNTEREN = 12'h306;
    localparam csr_addr_t ADDR_MSCRATCH   = 12'h340;
    localparam csr_addr_t ADDR_MEPC       = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE     = 12'h342;

    // Supervisor trap setup and handling
    localparam csr_addr_t ADDR_SSTATUS    = 12'h100;
    localparam csr_addr_t ADDR_SIE        = 12'h104;
    localparam csr_addr_t ADDR_STVEC      = 12'h105;
    localparam csr_addr_t ADDR_SCOUNTEREN = 12'h106;
    localparam csr_addr_t ADDR_SSCRATCH   = 12'h140;
    localparam csr_addr_t ADDR_SEPC       = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE     = 12'h142;

    localparam xlen_t MCAUSE_M_TIMER   = 32'h8000_0007;
    localparam xlen_t SCAUSE_S_TIMER   = 32'h8000_0005;
    localparam xlen_t ECALL_CAUSE_BASE = 32'd8;

    typedef struct packed {
        csr_cmd_e  cmd;
        csr_addr_t addr;
        xlen_t     op1;
    } csr_req_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    typedef struct packed {
        trap_kind_e kind;
        xlen_t      cause;
        xlen_t      epc;
    } trap_upd_t;

    typedef struct packed {
        priv_mode_e mode;
        // mstatus fields
        logic       mie;
        logic       mpie;
        priv_mode_e mpp;
        logic       sie;
        logic       spie;
        logic       spp;
        logic       mprv;
        logic       mxr;
        logic       sum;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mie_mtie;
        logic       mie_stie;
        logic       mideleg_mtie;
        // Bit 0 cycle, bit 1 time, bit 2 instret
        logic [2:0] mcounteren;
        logic [2:0] scounteren;
        xlen_t      mtvec;
        xlen_t      mscratch;
        xlen_t      mepc;
        xlen_t      mcause;
        xlen_t      stvec;
        xlen_t      sscratch;
        xlen_t      sepc;
        xlen_t      scause;
    } csr_state_t;

endpackage

// File: csr_read_stage.sv
`timescale 1ns/1ps

module csr_read_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_branch_hazard,
    input  csr_pkg::csr_cmd_e     csr_cmd,
    input  csr_pkg::xlen_t        op1_data,
    input  csr_pkg::xlen_t        imm_i,
    input  logic [63:0]           cycle_count,
    input  logic [63:0]           time_count,
    input  csr_pkg::csr_state_t   state,
    output csr_pkg::csr_req_t     req,
    output csr_pkg::csr_req_t     req_d,
    output csr_pkg::xlen_t        csr_rdata
);

    csr_pkg::xlen_t rdata_next;
    logic           cy_ok;
    logic           tm_ok;

    // Machine mode always, lower modes through the enable chain
    function automatic logic counter_ok(
        input csr_pkg::priv_mode_e mode,
        input logic                m_en,
        input logic                s_en
    );
        logic ok;
        ok = (mode == csr_pkg::MODE_MACHINE) ||
             (m_en && (mode == csr_pkg::MODE_SUPERVISOR ||
                       (mode == csr_pkg::MODE_USER && s_en)));
        return ok;
    endfunction

    // Hazard turns the command into a no-op reading an unmapped address
    always_comb begin
        if (wb_branch_hazard) begin
            req.cmd  = csr_pkg::CSR_X;
            req.addr = '1;
            req.op1  = '1;
        end else begin
            req.cmd  = csr_cmd;
            req.addr = imm_i[11:0];
            req.op1  = op1_data;
        end
    end

    assign cy_ok = counter_ok(state.mode, state.mcounteren[0], state.scounteren[0]);
    assign tm_ok = counter_ok(state.mode, state.mcounteren[1], state.scounteren[1]);

    always_comb begin
        case (req.addr)
            csr_pkg::ADDR_CYCLE:      rdata_next = cy_ok ? cycle_count[31:0] : '0;
            csr_pkg::ADDR_TIME:       rdata_next = tm_ok ? time_count[31:0] : '0;
            csr_pkg::ADDR_CYCLEH:     rdata_next = cy_ok ? cycle_count[63:32] : '0;
            csr_pkg::ADDR_TIMEH:      rdata_next = tm_ok ? time_count[63:32] : '0;
            csr_pkg::ADDR_MSTATUS: begin
                rdata_next = {9'b0, state.tsr, state.tw, state.tvm, state.mxr,
                              state.sum, state.mprv, 4'b0, state.mpp, 2'b0,
                              state.spp, state.mpie, 1'b0, state.spie, 1'b0,
                              state.mie, 1'b0, state.sie, 1'b0};
            end
            csr_pkg::ADDR_MIDELEG:    rdata_next = {24'b0, state.mideleg_mtie, 7'b0};
            csr_pkg::ADDR_MIE:        rdata_next = {24'b0, state.mie_mtie, 1'b0,
                                                    state.mie_stie, 5'b0};
            csr_pkg::ADDR_MTVEC:      rdata_next = state.mtvec;
            csr_pkg::ADDR_MCOUNTEREN: rdata_next = {29'b0, state.mcounteren};
            csr_pkg::ADDR_MSCRATCH:   rdata_next = state.mscratch;
            csr_pkg::ADDR_MEPC:       rdata_next = state.mepc;
            csr_pkg::ADDR_MCAUSE:     rdata_next = state.mcause;
            // Supervisor view of mstatus
            csr_pkg::ADDR_SSTATUS: begin
                rdata_next = {12'b0, state.mxr, state.sum, 9'b0, state.spp,
                              2'b0, state.spie, 3'b0, state.sie, 1'b0};
            end
            csr_pkg::ADDR_SIE:        rdata_next = {26'b0, state.mie_stie, 5'b0};
            csr_pkg::ADDR_STVEC:      rdata_next = state.stvec;
            csr_pkg::ADDR_SCOUNTEREN: rdata_next = {29'b0, state.scounteren};
            csr_pkg::ADDR_SSCRATCH:   rdata_next = state.sscratch;
            csr_pkg::ADDR_SEPC:       rdata_next = state.sepc;
            csr_pkg::ADDR_SCAUSE:     rdata_next = state.scause;
            default:                  rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rdata <= '0;
            req_d     <= '0;
        end else begin
            csr_rdata <= rdata_next;
            req_d     <= req;
        end
    end

endmodule

// File: csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile #(
    parameter csr_pkg::xlen_t MTVEC_RESET = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_wr_t      wr,
    input  csr_pkg::trap_upd_t    trap,
    output csr_pkg::csr_state_t   state
);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= '0;
            state.mode  <= csr_pkg::MODE_MACHINE;
            state.mpp   <= csr_pkg::MODE_MACHINE;
            state.mtvec <= MTVEC_RESET;
        end else begin
            // Privilege transitions first
            case (trap.kind)
                csr_pkg::TRAP_MACHINE: begin
                    state.mpp    <= state.mode;
                    state.mpie   <= state.mie;
                    state.mie    <= 1'b0;
                    state.mcause <= trap.cause;
                    state.mepc   <= trap.epc;
                    state.mode   <= csr_pkg::MODE_MACHINE;
                end
                csr_pkg::TRAP_SUPERVISOR: begin
                    state.spp    <= state.mode[0];
                    state.spie   <= state.sie;
                    state.sie    <= 1'b0;
                    state.scause <= trap.cause;
                    state.sepc   <= trap.epc;
                    state.mode   <= csr_pkg::MODE_SUPERVISOR;
                end
                csr_pkg::TRAP_ECALL: begin
                    state.mcause <= trap.cause;
                    state.mode   <= csr_pkg::MODE_MACHINE;
                end
                csr_pkg::TRAP_MRET: begin
                    state.mode <= state.mpp;
                    state.mpp  <= csr_pkg::MODE_USER;
                    state.mie  <= state.mpie;
                    // Leaving machine mode drops modified privilege
                    if (state.mpp != csr_pkg::MODE_MACHINE) begin
                        state.mprv <= 1'b0;
                    end
                end
                default: begin
                end
            endcase

            // Later assignment wins on a shared field
            if (wr.en) begin
                case (wr.addr)
                    csr_pkg::ADDR_MSTATUS: begin
                        state.tsr  <= wr.data[22];
                        state.tw   <= wr.data[21];
                        state.tvm  <= wr.data[20];
                        state.mxr  <= wr.data[19];
                        state.sum  <= wr.data[18];
                        state.mprv <= wr.data[17];
                        state.mpp  <= csr_pkg::priv_mode_e'(wr.data[12:11]);
                        state.spp  <= wr.data[8];
                        state.mpie <= wr.data[7];
                        state.spie <= wr.data[5];
                        state.mie  <= wr.data[3];
                        state.sie  <= wr.data[1];
                    end
                    csr_pkg::ADDR_MIDELEG:    state.mideleg_mtie <= wr.data[7];
                    csr_pkg::ADDR_MIE: begin
                        state.mie_mtie <= wr.data[7];
                        state.mie_stie <= wr.data[5];
                    end
                    csr_pkg::ADDR_MTVEC:      state.mtvec      <= wr.data;
                    csr_pkg::ADDR_MCOUNTEREN: state.mcounteren <= wr.data[2:0];
                    csr_pkg::ADDR_MSCRATCH:   state.mscratch   <= wr.data;
                    csr_pkg::ADDR_MEPC:       state.mepc       <= wr.data;
                    csr_pkg::ADDR_MCAUSE:     state.mcause     <= wr.data;
                    // Supervisor subset of mstatus only
                    csr_pkg::ADDR_SSTATUS: begin
                        state.mxr  <= wr.data[19];
                        state.sum  <= wr.data[18];
                        state.spp  <= wr.data[8];
                        state.spie <= wr.data[5];
                        state.sie  <= wr.data[1];
                    end
                    csr_pkg::ADDR_SIE:        state.mie_stie   <= wr.data[5];
                    csr_pkg::ADDR_STVEC:      state.stvec      <= wr.data;
                    csr_pkg::ADDR_SCOUNTEREN: state.scounteren <= wr.data[2:0];
                    csr_pkg::ADDR_SSCRATCH:   state.sscratch   <= wr.data;
                    csr_pkg::ADDR_SEPC:       state.sepc       <= wr.data;
                    csr_pkg::ADDR_SCAUSE:     state.scause     <= wr.data;
                    // Counters are read only
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: csr_trap_unit.sv
`timescale 1ns/1ps

module csr_trap_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_req_t     req,
    input  csr_pkg::csr_req_t     req_d,
    input  csr_pkg::xlen_t        csr_rdata,
    input  csr_pkg::csr_state_t   state,
    input  logic [63:0]           mtime,
    input  logic [63:0]           mtimecmp,
    input  logic                  interrupt_ready,
    input  csr_pkg::xlen_t        if_pc,
    output csr_pkg::csr_wr_t      wr,
    output csr_pkg::trap_upd_t    trap,
    output csr_pkg::csr_cmd_e     out_csr_cmd,
    output csr_pkg::xlen_t        trap_vector,
    output logic                  stall_may_interrupt
);

    logic           m_timer_en;
    logic           s_timer_en;
    logic           take_timer;
    logic           load_vector;
    csr_pkg::xlen_t vector_next;

    assign m_timer_en = state.mode == csr_pkg::MODE_MACHINE && state.mie_mtie &&
                        !state.mideleg_mtie && state.mie;
    assign s_timer_en = state.mode == csr_pkg::MODE_SUPERVISOR && state.mie_stie &&
                        state.sie;

    // Early warning so the front end can drain
    assign stall_may_interrupt = (mtime >= mtimecmp) && (m_timer_en || s_timer_en);
    assign take_timer = stall_may_interrupt && interrupt_ready;

    always_comb begin
        trap        = '0;
        load_vector = 1'b0;
        vector_next = state.mtvec;
        if (take_timer) begin
            load_vector = 1'b1;
            trap.epc    = if_pc;
            // Supervisor takes it only when delegated
            if (state.mode == csr_pkg::MODE_SUPERVISOR && state.mideleg_mtie) begin
                trap.kind   = csr_pkg::TRAP_SUPERVISOR;
                trap.cause  = csr_pkg::SCAUSE_S_TIMER;
                vector_next = state.stvec;
            end else begin
                trap.kind  = csr_pkg::TRAP_MACHINE;
                trap.cause = csr_pkg::MCAUSE_M_TIMER;
            end
        end else begin
            case (req.cmd)
                csr_pkg::CSR_ECALL: begin
                    load_vector = 1'b1;
                    trap.kind   = csr_pkg::TRAP_ECALL;
                    trap.cause  = csr_pkg::ECALL_CAUSE_BASE + {30'b0, state.mode};
                end
                csr_pkg::CSR_MRET: begin
                    load_vector = 1'b1;
                    trap.kind   = csr_pkg::TRAP_MRET;
                    vector_next = state.mepc;
                end
                default: begin
                end
            endcase
        end
    end

    // Write-back of the previous command
    always_comb begin
        wr.addr = req_d.addr;
        case (req_d.cmd)
            csr_pkg::CSR_W: begin
                wr.en   = 1'b1;
                wr.data = req_d.op1;
            end
            csr_pkg::CSR_S: begin
                wr.en   = 1'b1;
                wr.data = csr_rdata | req_d.op1;
            end
            csr_pkg::CSR_C: begin
                wr.en   = 1'b1;
                wr.data = csr_rdata & ~req_d.op1;
            end
            default: begin
                wr.en   = 1'b0;
                wr.data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_csr_cmd <= csr_pkg::CSR_X;
            // Regfile holds the reset vector in mtvec
            trap_vector <= state.mtvec;
        end else begin
            out_csr_cmd <= take_timer ? csr_pkg::CSR_ECALL : req.cmd;
            if (load_vector) begin
                trap_vector <= vector_next;
            end
        end
    end

endmodule

// File: csr_stage.sv
`timescale 1ns/1ps

module csr_stage #(
    parameter csr_pkg::xlen_t MTVEC_RESET = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [63:0]         cycle_count,
    input  logic [63:0]         time_count,
    input  logic [63:0]         mtime,
    input  logic [63:0]         mtimecmp,
    input  logic                wb_branch_hazard,
    input  csr_pkg::csr_cmd_e   csr_cmd,
    input  csr_pkg::xlen_t      op1_data,
    input  csr_pkg::xlen_t      imm_i,
    input  logic                interrupt_ready,
    input  csr_pkg::xlen_t      if_pc,
    output csr_pkg::csr_cmd_e   out_csr_cmd,
    output csr_pkg::xlen_t      csr_rdata,
    output csr_pkg::xlen_t      trap_vector,
    output logic                stall_may_interrupt
);

    csr_pkg::csr_req_t   req;
    csr_pkg::csr_req_t   req_d;
    csr_pkg::csr_state_t state;
    csr_pkg::csr_wr_t    wr;
    csr_pkg::trap_upd_t  trap;

    csr_read_stage i_read (
        .clk              (clk),
        .rst              (rst),
        .wb_branch_hazard (wb_branch_hazard),
        .csr_cmd          (csr_cmd),
        .op1_data         (op1_data),
        .imm_i            (imm_i),
        .cycle_count      (cycle_count),
        .time_count       (time_count),
        .state            (state),
        .req              (req),
        .req_d            (req_d),
        .csr_rdata        (csr_rdata)
    );

    csr_regfile #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_regfile (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .trap  (trap),
        .state (state)
    );

    csr_trap_unit i_trap (
        .clk                 (clk),
        .rst                 (rst),
        .req                 (req),
        .req_d               (req_d),
        .csr_rdata           (csr_rdata),
        .state               (state),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .interrupt_ready     (interrupt_ready),
        .if_pc               (if_pc),
        .wr                  (wr),
        .trap                (trap),
        .out_csr_cmd         (out_csr_cmd),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

endmodule

// File: csr_stage_sva.sv
`timescale 1ns/1ps

module csr_stage_sva (
    input logic                clk,
    input logic                rst,
    input logic                wb_branch_hazard,
    input csr_pkg::csr_cmd_e   csr_cmd,
    input logic                interrupt_ready,
    input logic                stall_may_interrupt,
    input csr_pkg::csr_cmd_e   out_csr_cmd,
    input csr_pkg::xlen_t      trap_vector,
    input csr_pkg::csr_state_t state
);

    logic timer_taken;
    logic ecall_in;

    assign timer_taken = stall_may_interrupt && interrupt_ready;
    // Timer trap overrides the incoming command
    assign ecall_in    = !wb_branch_hazard && csr_cmd == csr_pkg::CSR_ECALL && !timer_taken;

    a_reset_cmd: assert property (@(posedge clk) rst |=> out_csr_cmd == csr_pkg::CSR_X)
        else $error("out_csr_cmd is not idle after reset");

    a_ecall_vector: assert property (@(posedge clk) disable iff (rst)
        ecall_in |=> trap_vector == $past(state.mtvec))
        else $error("trap_vector did not follow mtvec one cycle after an ECALL");

    a_timer_cmd: assert property (@(posedge clk) disable iff (rst)
        timer_taken |=> out_csr_cmd == csr_pkg::CSR_ECALL)
        else $error("out_csr_cmd is not ECALL one cycle after a timer trap");

    a_flush_cmd: assert property (@(posedge clk) disable iff (rst)
        wb_branch_hazard && !timer_taken |=> out_csr_cmd == csr_pkg::CSR_X)
        else $error("flushed command reached out_csr_cmd");

endmodule

bind csr_stage csr_stage_sva i_sva (
    .clk                 (clk),
    .rst                 (rst),
    .wb_branch_hazard    (wb_branch_hazard),
    .csr_cmd             (csr_cmd),
    .interrupt_ready     (interrupt_ready),
    .stall_may_interrupt (stall_may_interrupt),
    .out_csr_cmd         (out_csr_cmd),
    .trap_vector         (trap_vector),
    .state               (state)
);

// File: tb_csr_stage.sv
`timescale 1ns/1ps

module tb_csr_stage;

    localparam csr_pkg::xlen_t MTVEC_RESET  = 32'h0000_0100;
    // Writable mstatus bits and the sstatus subset of them
    localparam csr_pkg::xlen_t MSTATUS_MASK = 32'h007e_19aa;
    localparam csr_pkg::xlen_t SSTATUS_MASK = 32'h000c_0122;
    localparam int             TIMEOUT      = 20;

    logic              clk;
    logic              rst;
    logic [63:0]       cycle_count;
    logic [63:0]       time_count;
    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic              wb_branch_hazard;
    csr_pkg::csr_cmd_e csr_cmd;
    csr_pkg::xlen_t    op1_data;
    csr_pkg::xlen_t    imm_i;
    logic              interrupt_ready;
    csr_pkg::xlen_t    if_pc;
    csr_pkg::csr_cmd_e out_csr_cmd;
    csr_pkg::xlen_t    csr_rdata;
    csr_pkg::xlen_t    trap_vector;
    logic              stall_may_interrupt;

    integer            seed;
    csr_pkg::csr_cmd_e seen_cmd;
    csr_pkg::xlen_t    seen_vec;
    csr_pkg::xlen_t    rd;
    csr_pkg::xlen_t    val;
    csr_pkg::xlen_t    exp_val;
    csr_pkg::xlen_t    scratch_val;
    csr_pkg::xlen_t    mtvec_val;
    csr_pkg::xlen_t    stvec_val;
    csr_pkg::xlen_t    pc_m;
    csr_pkg::xlen_t    pc_s;

    csr_stage #(.MTVEC_RESET (MTVEC_RESET)) i_dut (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "testbench stopped on error");
    endtask

    task automatic compare_value(input string name, input csr_pkg::xlen_t expected,
                                 input csr_pkg::xlen_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // One command, then an idle cycle so its write lands before the next one
    task automatic issue_cmd(input csr_pkg::csr_cmd_e cmd, input csr_pkg::csr_addr_t addr,
                             input csr_pkg::xlen_t op1);
        csr_cmd  = cmd;
        imm_i    = {20'b0, addr};
        op1_data = op1;
        @(posedge clk);
        #1;
        rd       = csr_rdata;
        seen_cmd = out_csr_cmd;
        seen_vec = trap_vector;
        csr_cmd  = csr_pkg::CSR_X;
        imm_i    = '0;
        op1_data = '0;
        @(posedge clk);
        #1;
    endtask

    // csrrs with a zero mask
    task automatic expect_read(input csr_pkg::csr_addr_t addr, input string name,
                               input csr_pkg::xlen_t expected);
        issue_cmd(csr_pkg::CSR_S, addr, '0);
        compare_value(name, expected, rd);
    endtask

    task automatic exercise_rmw(input csr_pkg::csr_addr_t addr, input string name,
                                output csr_pkg::xlen_t final_val);
        csr_pkg::xlen_t mask;
        csr_pkg::xlen_t model;
        model = $random(seed);
        issue_cmd(csr_pkg::CSR_W, addr, model);
        expect_read(addr, name, model);
        mask = $random(seed);
        issue_cmd(csr_pkg::CSR_S, addr, mask);
        model = model | mask;
        expect_read(addr, name, model);
        mask = $random(seed);
        issue_cmd(csr_pkg::CSR_C, addr, mask);
        model = model & ~mask;
        expect_read(addr, name, model);
        final_val = model;
    endtask

    task automatic counter_gating(input logic visible);
        expect_read(csr_pkg::ADDR_CYCLE, "cycle", visible ? cycle_count[31:0] : '0);
        expect_read(csr_pkg::ADDR_TIME, "time", visible ? time_count[31:0] : '0);
        expect_read(csr_pkg::ADDR_CYCLEH, "cycleh", visible ? cycle_count[63:32] : '0);
        expect_read(csr_pkg::ADDR_TIMEH, "timeh", visible ? time_count[63:32] : '0);
    endtask

    task automatic wait_for_stall();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!stall_may_interrupt && cycles < TIMEOUT);
        if (!stall_may_interrupt) begin
            abort_run("Timeout: stall_may_interrupt never rose while the timer was due");
        end
    endtask

    task automatic take_timer_trap(input csr_pkg::xlen_t pc);
        int cycles;
        interrupt_ready = 1'b1;
        if_pc           = pc;
        cycles          = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (out_csr_cmd != csr_pkg::CSR_ECALL && cycles < TIMEOUT);
        interrupt_ready = 1'b0;
        mtimecmp        = '1;
        if (out_csr_cmd != csr_pkg::CSR_ECALL) begin
            abort_run("Timeout: no timer trap was taken after interrupt_ready rose");
        end
    endtask

    initial begin
        seed             = 32'h9baf_9dfa;
        clk              = 1'b0;
        rst              = 1'b1;
        cycle_count      = '0;
        time_count       = '0;
        // Timer due from the start so the reset enables alone keep the stall low
        mtime            = '0;
        mtimecmp         = '0;
        wb_branch_hazard = 1'b0;
        csr_cmd          = csr_pkg::CSR_X;
        op1_data         = '0;
        imm_i            = '0;
        interrupt_ready  = 1'b0;
        if_pc            = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_value("out_csr_cmd", {29'b0, csr_pkg::CSR_X}, {29'b0, out_csr_cmd});
        compare_value("csr_rdata", '0, csr_rdata);
        compare_value("trap_vector", MTVEC_RESET, trap_vector);
        compare_value("stall_may_interrupt", '0, {31'b0, stall_may_interrupt});
        mtimecmp = '1;

        exercise_rmw(csr_pkg::ADDR_MSCRATCH, "mscratch", scratch_val);
        exercise_rmw(csr_pkg::ADDR_MTVEC, "mtvec", mtvec_val);
        val = $random(seed);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, val);
        exp_val = val & MSTATUS_MASK;
        val = $random(seed);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_SSTATUS, val);
        exp_val = (exp_val & ~SSTATUS_MASK) | (val & SSTATUS_MASK);
        expect_read(csr_pkg::ADDR_MSTATUS, "mstatus", exp_val);
        expect_read(csr_pkg::ADDR_SSTATUS, "sstatus", exp_val & SSTATUS_MASK);

        // Flushed write must vanish
        wb_branch_hazard = 1'b1;
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSCRATCH, ~scratch_val);
        wb_branch_hazard = 1'b0;
        compare_value("csr_rdata", '0, rd);
        compare_value("out_csr_cmd", {29'b0, csr_pkg::CSR_X}, {29'b0, seen_cmd});
        expect_read(csr_pkg::ADDR_MSCRATCH, "mscratch", scratch_val);

        // mpie set, mpp user
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, 32'h0000_0080);
        val = $random(seed) & ~32'h3;
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MEPC, val);
        issue_cmd(csr_pkg::CSR_MRET, '0, '0);
        compare_value("trap_vector", val, seen_vec);
        compare_value("out_csr_cmd", {29'b0, csr_pkg::CSR_MRET}, {29'b0, seen_cmd});
        issue_cmd(csr_pkg::CSR_ECALL, '0, '0);
        compare_value("trap_vector", mtvec_val, seen_vec);
        expect_read(csr_pkg::ADDR_MCAUSE, "mcause", csr_pkg::ECALL_CAUSE_BASE + 32'd0);
        issue_cmd(csr_pkg::CSR_ECALL, '0, '0);
        expect_read(csr_pkg::ADDR_MCAUSE, "mcause", csr_pkg::ECALL_CAUSE_BASE + 32'd3);

        cycle_count = {$random(seed), $random(seed)};
        time_count  = {$random(seed), $random(seed)};
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, '0);
        issue_cmd(csr_pkg::CSR_MRET, '0, '0);
        counter_gating(1'b0);
        issue_cmd(csr_pkg::CSR_ECALL, '0, '0);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MCOUNTEREN, 32'h3);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_SCOUNTEREN, 32'h3);
        issue_cmd(csr_pkg::CSR_MRET, '0, '0);
        counter_gating(1'b1);
        issue_cmd(csr_pkg::CSR_ECALL, '0, '0);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MCOUNTEREN, '0);
        counter_gating(1'b1);

        // New mtvec so the trap vector only matches if the timer trap loads it
        mtvec_val = ~mtvec_val;
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MTVEC, mtvec_val);

        // Machine timer with mtie and mstatus.mie
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIE, 32'h0000_0080);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        mtime    = 64'd1000;
        mtimecmp = 64'd1000;
        wait_for_stall();
        pc_m = $random(seed) & ~32'h3;
        take_timer_trap(pc_m);
        compare_value("trap_vector", mtvec_val, trap_vector);
        expect_read(csr_pkg::ADDR_MEPC, "mepc", pc_m);
        expect_read(csr_pkg::ADDR_MCAUSE, "mcause", csr_pkg::MCAUSE_M_TIMER);
        // mpp machine, mpie from old mie, mie clear
        expect_read(csr_pkg::ADDR_MSTATUS, "mstatus", 32'h0000_1880);

        stvec_val = $random(seed) & ~32'h3;
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_STVEC, stvec_val);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIDELEG, 32'h0000_0080);
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MIE, 32'h0000_00a0);
        // mpp supervisor, sie set
        issue_cmd(csr_pkg::CSR_W, csr_pkg::ADDR_MSTATUS, 32'h0000_0802);
        issue_cmd(csr_pkg::CSR_MRET, '0, '0);
        compare_value("trap_vector", pc_m, seen_vec);
        mtimecmp = 64'd1000;
        wait_for_stall();
        pc_s = $random(seed) & ~32'h3;
        take_timer_trap(pc_s);
        compare_value("trap_vector", stvec_val, trap_vector);
        expect_read(csr_pkg::ADDR_SEPC, "sepc", pc_s);
        expect_read(csr_pkg::ADDR_SCAUSE, "scause", csr_pkg::SCAUSE_S_TIMER);
        expect_read(csr_pkg::ADDR_MEPC, "mepc", pc_m);
        expect_read(csr_pkg::ADDR_MCAUSE, "mcause", csr_pkg::MCAUSE_M_TIMER);
        // spp and spie set, machine fields as left by mret
        expect_read(csr_pkg::ADDR_MSTATUS, "mstatus", 32'h0000_0120);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb.f
csr_pkg.sv
csr_read_stage.sv
csr_regfile.sv
csr_trap_unit.sv
csr_stage.sv
csr_stage_sva.sv
tb_csr_stage.sv

// File: Makefile
# Verilator build and run of the CSR stage testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR) VFLAGS=\"$(VFLAGS)\""

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
